// File: common/emu_pkg.sv
`default_nettype none

package emu_pkg;

    // slice and history geometry
    localparam int NUM_SLICES = 4;
    localparam int CHUNK_SYMS = 4;
    localparam int NUM_CHUNKS = 4;
    localparam int HIST_SYMS  = NUM_CHUNKS * CHUNK_SYMS; // 16 symbols
    localparam int CHUNK_IDX_BITS = $clog2(NUM_CHUNKS);

    // frame timing, one cycle per chunk plus idle and last cycle
    localparam int FRAME_CYCLES = NUM_CHUNKS + 2;
    localparam int FRAME_CNT_BITS = $clog2(FRAME_CYCLES);
    localparam int CLK_FALL = 2;                          // adc clock goes low here
    localparam int CLK_RISE = CLK_FALL + (FRAME_CYCLES / 2) - 1; // last low count

    // phase interpolator code
    localparam int PI_BITS = 7;
    localparam int PI_MAX  = (1 << PI_BITS) - 1;

    // datapath widths
    localparam int COEF_WIDTH = 8;
    localparam int SUM_WIDTH  = 12;
    localparam int ADC_WIDTH  = 8;
    localparam int ADC_MAX    = (1 << ADC_WIDTH) - 1;

    // host bus and received word
    localparam int WB_ADDR_WIDTH = 6;
    localparam int WB_DATA_WIDTH = 8;
    localparam int RX_WORD_WIDTH = CHUNK_SYMS + 1;        // room for an early slip

    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    // one chunk's worth of step response, element k weighs symbol k of the chunk
    typedef coef_t [CHUNK_SYMS-1:0] chunk_coef_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                 sgn; // set when the sum is negative
        logic [ADC_WIDTH-1:0] mag;
    } slice_out_t;

endpackage

`default_nettype wire

// File: rtl/frame_sequencer.sv
`default_nettype none

module frame_sequencer import emu_pkg::*; (
    input  wire logic                      emu_clk,
    input  wire logic                      emu_rst,
    output logic [CHUNK_IDX_BITS-1:0]      chunk_idx_o,
    output logic                           acc_load_o,
    output logic                           last_cycle_o,
    output logic                           clk_adc_o
);

    logic [FRAME_CNT_BITS-1:0] frame_cnt;
    logic [FRAME_CNT_BITS-1:0] frame_cnt_next;
    logic                      clk_adc_q;

    always_comb begin
        if (frame_cnt == FRAME_CNT_BITS'(FRAME_CYCLES - 1)) begin
            frame_cnt_next = '0; // wrap after the last cycle
        end else begin
            frame_cnt_next = frame_cnt + 1'b1;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt_next;
        end
    end

    // adc clock is registered from the next count so it comes straight off a flop
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            clk_adc_q <= 1'b1;
        end else begin
            clk_adc_q <= !((frame_cnt_next >= FRAME_CNT_BITS'(CLK_FALL)) &&
                           (frame_cnt_next <= FRAME_CNT_BITS'(CLK_RISE)));
        end
    end

    // chunk index parks at 0 during the idle and last cycles
    assign chunk_idx_o  = (frame_cnt < FRAME_CNT_BITS'(NUM_CHUNKS)) ?
                          frame_cnt[CHUNK_IDX_BITS-1:0] : '0;
    assign acc_load_o   = (frame_cnt == '0);
    assign last_cycle_o = (frame_cnt == FRAME_CNT_BITS'(FRAME_CYCLES - 1));
    assign clk_adc_o    = clk_adc_q;

endmodule

`default_nettype wire

// File: rtl/step_response_ram.sv
`default_nettype none

module step_response_ram import emu_pkg::*; (
    input  wire logic                      emu_clk,
    input  wire logic                      emu_rst,
    input  wire wb_req_t                   wb_req_i,
    output wb_rsp_t                        wb_rsp_o,
    input  wire logic [CHUNK_IDX_BITS-1:0] chunk_idx_i,
    output chunk_coef_t                    coef_o [NUM_SLICES]
);

    localparam int DEPTH = 1 << WB_ADDR_WIDTH;
    localparam int SLICE_BITS = $clog2(NUM_SLICES);
    localparam int SYM_BITS = $clog2(CHUNK_SYMS);

    coef_t                    mem [DEPTH];
    logic                     ack_q;
    logic [WB_DATA_WIDTH-1:0] rd_dat_q;
    logic                     bus_req;

    // a new request is taken only when no ack is pending, which gives one wait state
    assign bus_req = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req;
        end
    end

    // coefficients come up as zero so an unwritten slice outputs zero
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int a = 0; a < DEPTH; a++) begin
                mem[a] <= '0;
            end
        end else if (bus_req && wb_req_i.we) begin
            mem[wb_req_i.adr] <= coef_t'(wb_req_i.dat);
        end
    end

    always_ff @(posedge emu_clk) begin
        if (bus_req && !wb_req_i.we) begin
            rd_dat_q <= mem[wb_req_i.adr];
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;

    // address is {slice, chunk, symbol within chunk}
    for (genvar s = 0; s < NUM_SLICES; s++) begin : g_slice_port
        localparam logic [SLICE_BITS-1:0] SLICE_NUM = SLICE_BITS'(s);

        for (genvar k = 0; k < CHUNK_SYMS; k++) begin : g_coef
            logic [WB_ADDR_WIDTH-1:0] rd_adr;

            assign rd_adr = {SLICE_NUM, chunk_idx_i, SYM_BITS'(k)};
            assign coef_o[s][k] = mem[rd_adr];
        end
    end

endmodule

`default_nettype wire

// File: analog_core/symbol_history.sv
`default_nettype none

module symbol_history import emu_pkg::*; (
    input  wire logic                      emu_clk,
    input  wire logic                      emu_rst,
    input  wire logic                      last_cycle_i,
    input  wire logic [RX_WORD_WIDTH-1:0]  rx_symbols_i,
    input  wire logic [PI_BITS-1:0]        pi_code_i,
    input  wire logic [CHUNK_IDX_BITS-1:0] chunk_idx_i,
    output logic [CHUNK_SYMS-1:0]          chunk_o,
    output logic [1:0]                     slip_o
);

    logic [HIST_SYMS-1:0] history;      // bit 0 is the oldest symbol
    logic [HIST_SYMS-1:0] next_history;
    logic [PI_BITS-1:0]   last_pi_code;
    logic                 pi_early;
    logic                 pi_late;
    logic [1:0]           slip_q;

    // phase wrapped forward one full symbol, so an extra symbol arrived
    assign pi_early = (last_pi_code == PI_BITS'(PI_MAX)) && (pi_code_i == '0);
    // wrapped backward, one symbol fewer this frame
    assign pi_late  = (last_pi_code == '0) && (pi_code_i == PI_BITS'(PI_MAX));

    always_comb begin
        if (pi_early) begin
            next_history = {rx_symbols_i[CHUNK_SYMS:0], history[HIST_SYMS-1:CHUNK_SYMS+1]};
        end else if (pi_late) begin
            next_history = {rx_symbols_i[CHUNK_SYMS-2:0], history[HIST_SYMS-1:CHUNK_SYMS-1]};
        end else begin
            next_history = {rx_symbols_i[CHUNK_SYMS-1:0], history[HIST_SYMS-1:CHUNK_SYMS]};
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history      <= '0;
            last_pi_code <= '0;
            slip_q       <= 2'b00;
        end else if (last_cycle_i) begin
            history      <= next_history;
            last_pi_code <= pi_code_i;
            slip_q       <= {pi_early, pi_late}; // 10 early, 01 late
        end
    end

    // chunk c covers symbols 4c to 4c+3
    assign chunk_o = history[chunk_idx_i*CHUNK_SYMS +: CHUNK_SYMS];
    assign slip_o  = slip_q;

endmodule

`default_nettype wire

// File: analog_core/analog_slice.sv
`default_nettype none

module analog_slice import emu_pkg::*; (
    input  wire logic                  emu_clk,
    input  wire logic                  emu_rst,
    input  wire logic [CHUNK_SYMS-1:0] chunk_i,
    input  wire chunk_coef_t           coef_i,
    input  wire logic                  acc_load_i,
    input  wire logic                  last_cycle_i,
    output slice_out_t                 result_o
);

    localparam int ADDS_BITS = $clog2(NUM_CHUNKS);

    logic signed [SUM_WIDTH-1:0] chunk_sum;
    logic signed [SUM_WIDTH-1:0] acc;
    logic [ADDS_BITS-1:0]        adds_left; // chunks still to add after the load
    logic [SUM_WIDTH-1:0]        acc_abs;
    slice_out_t                  result_q;

    // a 1 adds the step coefficient, a 0 subtracts it
    always_comb begin
        logic signed [SUM_WIDTH-1:0] term;

        chunk_sum = '0;
        for (int k = 0; k < CHUNK_SYMS; k++) begin
            term = SUM_WIDTH'(coef_i[k]);
            chunk_sum = chunk_i[k] ? (chunk_sum + term) : (chunk_sum - term);
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc       <= '0;
            adds_left <= '0;
        end else if (acc_load_i) begin
            acc       <= chunk_sum;              // chunk 0 starts the frame
            adds_left <= ADDS_BITS'(NUM_CHUNKS - 1);
        end else if (adds_left != '0) begin
            acc       <= acc + chunk_sum;
            adds_left <= adds_left - 1'b1;
        end
    end

    // unsigned view, so even the most negative sum has a proper magnitude
    assign acc_abs = (acc < 0) ? (-acc) : acc;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            result_q <= '0;
        end else if (last_cycle_i) begin
            result_q.sgn <= (acc < 0);
            if (acc_abs > SUM_WIDTH'(ADC_MAX)) begin
                result_q.mag <= ADC_WIDTH'(ADC_MAX); // clip at full scale
            end else begin
                result_q.mag <= acc_abs[ADC_WIDTH-1:0];
            end
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

// File: rtl/rx_emulator_top.sv
`default_nettype none

module rx_emulator_top import emu_pkg::*; (
    input  wire logic                     emu_clk,
    input  wire logic                     emu_rst,
    input  wire wb_req_t                  wb_req_i,
    output wb_rsp_t                       wb_rsp_o,
    input  wire logic [RX_WORD_WIDTH-1:0] rx_symbols_i,
    input  wire logic [PI_BITS-1:0]       pi_code_i,
    output slice_out_t                    results_o [NUM_SLICES],
    output logic                          adc_valid_o,
    output logic                          clk_adc_o,
    output logic [1:0]                    slip_o
);

    logic [CHUNK_IDX_BITS-1:0] chunk_idx;
    logic                      acc_load;
    logic                      last_cycle;
    logic [CHUNK_SYMS-1:0]     chunk;
    chunk_coef_t               slice_coef [NUM_SLICES];
    logic                      adc_valid_q;

    frame_sequencer i_frame_sequencer (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .chunk_idx_o  (chunk_idx),
        .acc_load_o   (acc_load),
        .last_cycle_o (last_cycle),
        .clk_adc_o    (clk_adc_o)
    );

    step_response_ram i_step_response_ram (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .chunk_idx_i (chunk_idx),
        .coef_o      (slice_coef)
    );

    symbol_history i_symbol_history (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .last_cycle_i (last_cycle),
        .rx_symbols_i (rx_symbols_i),
        .pi_code_i    (pi_code_i),
        .chunk_idx_i  (chunk_idx),
        .chunk_o      (chunk),
        .slip_o       (slip_o)
    );

    // all slices see the same chunk, each with its own step response
    for (genvar s = 0; s < NUM_SLICES; s++) begin : g_slice
        analog_slice i_analog_slice (
            .emu_clk      (emu_clk),
            .emu_rst      (emu_rst),
            .chunk_i      (chunk),
            .coef_i       (slice_coef[s]),
            .acc_load_i   (acc_load),
            .last_cycle_i (last_cycle),
            .result_o     (results_o[s])
        );
    end

    // results are registered on the last cycle, so valid follows one clock later
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_valid_q <= 1'b0;
        end else begin
            adc_valid_q <= last_cycle;
        end
    end

    assign adc_valid_o = adc_valid_q;

endmodule

`default_nettype wire

// File: tb/rx_emulator_checker.sv
`default_nettype none

module rx_emulator_checker import emu_pkg::*; (
    input wire logic                      emu_clk,
    input wire logic                      emu_rst,
    input wire wb_req_t                   wb_req_i,
    input wire wb_rsp_t                   wb_rsp_i,
    input wire logic                      adc_valid_i,
    input wire logic                      clk_adc_i,
    input wire logic [FRAME_CNT_BITS-1:0] frame_cnt_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // failed assertion attempts

    ack_in_cycle: assert property (@(posedge emu_clk) disable iff (emu_rst)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_count++;
            $error("ack seen outside an active bus cycle");
        end

    ack_single: assert property (@(posedge emu_clk) disable iff (emu_rst)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack held for two cycles");
        end

    // one valid pulse per 6-cycle frame
    valid_period: assert property (@(posedge emu_clk) disable iff (emu_rst)
        adc_valid_i |-> ##1 !adc_valid_i ##1 !adc_valid_i ##1 !adc_valid_i
                        ##1 !adc_valid_i ##1 !adc_valid_i ##1 adc_valid_i)
        else begin
            fail_count++;
            $error("adc_valid_o period is not one frame");
        end

    // low at counts 2 to 4, high at the other three
    adc_clk_phase: assert property (@(posedge emu_clk) disable iff (emu_rst)
        clk_adc_i == !(frame_cnt_i inside {3'd2, 3'd3, 3'd4}))
        else begin
            fail_count++;
            $error("clk_adc_o out of phase with the frame");
        end

endmodule

bind rx_emulator_top rx_emulator_checker i_rx_emulator_checker (
    .emu_clk     (emu_clk),
    .emu_rst     (emu_rst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_i    (wb_rsp_o),
    .adc_valid_i (adc_valid_o),
    .clk_adc_i   (clk_adc_o),
    .frame_cnt_i (i_frame_sequencer.frame_cnt)
);

`default_nettype wire

// File: tb/tb_rx_emulator.sv
`default_nettype none

module tb_rx_emulator import emu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam string STIM_FILE = "tb/stimulus_input.txt";

    logic                     emu_clk;
    logic                     emu_rst;
    wb_req_t                  wb_req;
    wb_rsp_t                  wb_rsp;
    logic [RX_WORD_WIDTH-1:0] rx_symbols;
    logic [PI_BITS-1:0]       pi_code;
    slice_out_t               results [NUM_SLICES];
    logic                     adc_valid;
    logic                     clk_adc;
    logic [1:0]               slip;

    logic [WB_ADDR_WIDTH-1:0] wr_adr_q [$];     // coefficient writes from the data file
    logic [7:0]               wr_dat_q [$];
    logic [RX_WORD_WIDTH-1:0] frame_word_q [$];
    logic [PI_BITS-1:0]       frame_code_q [$];
    logic [1:0]               frame_slip_q [$]; // expected slip_o per frame
    logic                     stim_loaded = 1'b0;

    // reference model state
    logic signed [COEF_WIDTH-1:0] coef_model [1 << WB_ADDR_WIDTH];
    logic [HIST_SYMS-1:0]         model_hist;   // bit 0 oldest
    int                           model_pi;

    rx_emulator_top i_rx_emulator_top (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .rx_symbols_i (rx_symbols),
        .pi_code_i    (pi_code),
        .results_o    (results),
        .adc_valid_o  (adc_valid),
        .clk_adc_o    (clk_adc),
        .slip_o       (slip)
    );

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) emu_clk = ~emu_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("Error at %0d ns: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic read_data_line(input int fd, output string line, output bit found);
        int n;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                found = 1'b1;
            end
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n_writes;
        int    a;
        int    c;
        int    d;
        string line;
        bit    found;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("could not open the stimulus file %s", STIM_FILE));
        end else begin
            read_data_line(fd, line, found);
            void'($sscanf(line, "%d", n_writes));
            for (int i = 0; i < n_writes; i++) begin
                read_data_line(fd, line, found);
                void'($sscanf(line, "%h %h", a, d));
                wr_adr_q.push_back(WB_ADDR_WIDTH'(a));
                wr_dat_q.push_back(8'(d));
            end
            read_data_line(fd, line, found);
            while (found) begin
                void'($sscanf(line, "%b %d %b", a, c, d));
                frame_word_q.push_back(RX_WORD_WIDTH'(a));
                frame_code_q.push_back(PI_BITS'(c));
                frame_slip_q.push_back(2'(d));
                read_data_line(fd, line, found);
            end
            $fclose(fd);
        end
    endtask

    // one classic cycle, the slave must answer after exactly one wait state
    task automatic wb_access(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int waits;
        waits = 0;
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(posedge emu_clk);
        while (!wb_rsp.ack && waits <= 4) begin
            waits++;
            @(posedge emu_clk);
        end
        rdat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no Wishbone ack for address %0h", adr));
        end else begin
            wb_req <= '0;                  // stb drops in the cycle after ack
            @(posedge emu_clk);
            check_value("wb_rsp_o.ack wait cycles", waits, 1);
        end
    endtask

    task automatic wait_pulse();
        @(posedge emu_clk);
        while (!adc_valid) begin
            @(posedge emu_clk);
        end
    endtask

    // +coef for a 1, -coef for a 0, summed over the whole history
    task automatic check_results(input logic [HIST_SYMS-1:0] hist);
        int sum;
        int mag;
        int term;
        for (int s = 0; s < NUM_SLICES; s++) begin
            sum = 0;
            for (int j = 0; j < HIST_SYMS; j++) begin
                term = int'(coef_model[s * HIST_SYMS + j]);
                sum  = hist[j] ? sum + term : sum - term;
            end
            mag = (sum < 0) ? -sum : sum;
            mag = (mag > ADC_MAX) ? ADC_MAX : mag;
            check_value($sformatf("results_o[%0d].sgn", s), int'(results[s].sgn),
                        (sum < 0) ? 1 : 0);
            check_value($sformatf("results_o[%0d].mag", s), int'(results[s].mag), mag);
        end
    endtask

    function automatic int symbols_in_frame(input int prev_code, input int code);
        int n;
        n = CHUNK_SYMS;
        if (prev_code == PI_MAX && code == 0) begin
            n = CHUNK_SYMS + 1;            // early, one extra symbol
        end else if (prev_code == 0 && code == PI_MAX) begin
            n = CHUNK_SYMS - 1;            // late
        end
        return n;
    endfunction

    function automatic logic [HIST_SYMS-1:0] shifted_history(
            input logic [HIST_SYMS-1:0] hist, input logic [RX_WORD_WIDTH-1:0] word,
            input int n);
        logic [HIST_SYMS-1:0] h;
        h = hist >> n;
        for (int b = 0; b < n; b++) begin
            h[HIST_SYMS - n + b] = word[b]; // new bits on top, bit 0 lowest
        end
        return h;
    endfunction

    // adc clock over one frame, starting in the pulse cycle at count 0
    task automatic check_adc_clock();
        wait_pulse();
        for (int k = 0; k < FRAME_CYCLES; k++) begin
            check_value($sformatf("clk_adc_o at count %0d", k), int'(clk_adc),
                        (k >= 2 && k <= 4) ? 0 : 1);
            if (k < FRAME_CYCLES - 1) begin
                @(posedge emu_clk);
            end
        end
    endtask

    initial begin
        int limit_ns;
        wait (stim_loaded);
        limit_ns = ((frame_word_q.size() + 6) * FRAME_CYCLES + wr_adr_q.size() * 8 + 10)
                   * CLK_PERIOD + 200;
        #(limit_ns);
        abort_run($sformatf("Timeout: the run did not finish within %0d ns", limit_ns));
    end

    // a failing bound assertion ends the run at once
    initial begin
        wait (i_rx_emulator_top.i_rx_emulator_checker.fail_count != 0);
        abort_run("a concurrent assertion in the checker failed");
    end

    initial begin
        int                   n_symbols;
        logic [HIST_SYMS-1:0] next_hist;
        logic [7:0]           rdat;

        emu_rst    <= 1'b1;
        wb_req     <= '0;
        rx_symbols <= '0;
        pi_code    <= PI_BITS'(64);      // mid code, no slip while flushing
        model_hist = '0;
        model_pi   = 64;
        foreach (coef_model[a]) begin
            coef_model[a] = '0;
        end
        load_stimulus();
        stim_loaded = 1'b1;

        repeat (3) @(posedge emu_clk);
        emu_rst <= 1'b0;
        @(posedge emu_clk);

        foreach (wr_adr_q[i]) begin
            wb_access(1'b1, wr_adr_q[i], wr_dat_q[i], rdat);
            coef_model[wr_adr_q[i]] = wr_dat_q[i];
        end
        foreach (wr_adr_q[i]) begin
            wb_access(1'b0, wr_adr_q[i], 8'h00, rdat);
            check_value($sformatf("wb_rsp_o.dat at %0h", wr_adr_q[i]), int'(rdat),
                        int'(wr_dat_q[i]));
        end

        wait_pulse();                      // may still hold partial coefficient sets
        wait_pulse();
        check_results(model_hist);

        // a word applied now is shifted in at this frame's last cycle
        foreach (frame_word_q[i]) begin
            rx_symbols <= frame_word_q[i];
            pi_code    <= frame_code_q[i];
            n_symbols = symbols_in_frame(model_pi, int'(frame_code_q[i]));
            next_hist = shifted_history(model_hist, frame_word_q[i], n_symbols);
            model_pi  = int'(frame_code_q[i]);
            wait_pulse();
            check_results(model_hist);
            check_value("slip_o", int'(slip), int'(frame_slip_q[i]));
            model_hist = next_hist;
        end
        wait_pulse();
        check_results(model_hist);
        check_adc_clock();

        if (i_rx_emulator_top.i_rx_emulator_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("concurrent assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: tb/stimulus_input.txt
# coefficient writes: a count line, then <address hex> <coefficient hex> per line
# frames: <symbol word binary> <pi code decimal> <expected slip_o binary>
10
0f 64
0e 5a
0c 50
10 3c
17 d8
23 7f
2b 7f
2f 14
38 ce
3d 19
10110 64 00
01011 64 00
11111 64 00
11111 64 00
00101 127 00
10011 0 10
01100 0 00
00111 127 01
11010 127 00
00000 64 00
10101 64 00

// File: files.f
common/emu_pkg.sv
rtl/frame_sequencer.sv
rtl/step_response_ram.sv
analog_core/symbol_history.sv
analog_core/analog_slice.sv
rtl/rx_emulator_top.sv
tb/rx_emulator_checker.sv
tb/tb_rx_emulator.sv

// File: Makefile
TOP = tb_rx_emulator

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -q "^ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
